/* build.f */
src/icache_pkg.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_miss_unit.sv
src/icache_ctrl.sv
src/icache_top.sv
sim/tb_icache_mem.sv
sim/tb_icache.sv

/* Bender.yml */
package:
  name: icache

sources:
  - src/icache_pkg.sv
  - src/icache_tag_array.sv
  - src/icache_data_array.sv
  - src/icache_miss_unit.sv
  - src/icache_ctrl.sv
  - src/icache_top.sv
  - target: simulation
    files:
      - sim/tb_icache_mem.sv
      - sim/tb_icache.sv

/* sim/icache_tests.txt */
# columns: fetch address (hex), expected word (hex), expected miss (1/0),
# idle cycles with valid low before the access
00000040 ffffffbf00000040 1 0
00000058 ffffffa700000058 0 0
00000048 ffffffb700000048 0 0
00000050 ffffffaf00000050 0 0
00000858 fffff7a700000858 1 0
00000040 ffffffbf00000040 0 2
00000848 fffff7b700000848 0 0
00000050 ffffffaf00000050 0 0
00000850 fffff7af00000850 0 0
00001048 ffffefb700001048 1 0
00000850 fffff7af00000850 0 0
00001058 ffffefa700001058 0 0
00000040 ffffffbf00000040 1 1
00001040 ffffefbf00001040 0 1
00000848 fffff7b700000848 1 0
00000058 ffffffa700000058 0 0
00000870 fffff78f00000870 1 0
00000860 fffff79f00000860 0 0
00000868 fffff79700000868 0 0
00000878 fffff78700000878 0 0
0001f3e8 fffe0c170001f3e8 1 0
0001f3f8 fffe0c070001f3f8 0 0
00000858 fffff7a700000858 0 3
00000048 ffffffb700000048 0 0
fffffff0 0000000ffffffff0 1 0
ffffffe0 0000001fffffffe0 0 0
00001058 ffffefa700001058 1 0
00000040 ffffffbf00000040 0 0

/* sim/tb_icache.sv */
// icache testbench top that runs the access list from the tests file and checks each response
`timescale 1ns/10ps
`default_nettype none

module tb_icache import icache_pkg::*; ();

  localparam int    NUM_SETS        = 64;
  localparam int    CLK_PERIOD      = 100;
  localparam int    DRIVE_DLY       = 5;
  localparam int    CYCLES_PER_TEST = 40;
  localparam string TEST_FILE       = "sim/icache_tests.txt";

  typedef struct packed {
    addr_t      addr;
    word_t      word;
    logic       miss;
    logic [7:0] gap;       // idle cycles before the access
  } test_rec_t;

  typedef struct packed {
    logic [31:0] idx;
    logic [31:0] acc_cyc;  // cycle the accept was seen
    logic [31:0] err_base;
    logic        miss_seen;
  } pending_t;

  logic        clk;
  logic        rst;
  logic        valid;
  addr_t       addr;
  logic        addr_ok;
  logic        data_ok;
  word_t       rdata;
  mem_rd_req_t mem_req;
  logic        rd_rdy;
  mem_ret_t    mem_ret;

  test_rec_t   tests[$];
  pending_t    pending[$];
  int unsigned cycle_q = 0;
  int          errors;
  int          tests_failed;
  int          done_count;
  int          issued;
  int          gap_left;
  logic        req_prev;
  logic [31:0] prev_acc;
  logic        loaded = 1'b0;

  icache_top #(.NUM_SETS(NUM_SETS)) u_icache_top (
    .i_clk     (clk),
    .i_rst     (rst),
    .i_valid   (valid),
    .i_addr    (addr),
    .o_addr_ok (addr_ok),
    .o_data_ok (data_ok),
    .o_rdata   (rdata),
    .o_mem_req (mem_req),
    .i_rd_rdy  (rd_rdy),
    .i_mem_ret (mem_ret)
  );

  tb_icache_mem u_mem (
    .i_clk     (clk),
    .i_mem_req (mem_req),
    .o_rd_rdy  (rd_rdy),
    .o_mem_ret (mem_ret)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle_q <= cycle_q + 1;

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  function automatic word_t model_word(addr_t a);
    addr_t w;
    w = {a[ADDR_W-1:3], 3'b000};   // word address
    return {~w, w};
  endfunction

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_error(string what);
    $display("%0t: %s", $time, what);
    errors++;
  endtask

  task automatic load_tests();
    int          fd;
    int          m;
    int          g;
    string       line;
    logic [31:0] a;
    logic [63:0] w;
    test_rec_t   rec;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      report_error("cannot open the test file");
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin   // skip comments and blanks
          if ($sscanf(line, "%h %h %d %d", a, w, m, g) == 4) begin
            rec.addr = a;
            rec.word = w;
            rec.miss = m[0];
            rec.gap  = g[7:0];
            check_value("tests file word", model_word(a), w);
            tests.push_back(rec);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_reset_outputs();
    check_value("o_addr_ok", 1, addr_ok);
    check_value("o_data_ok", 0, data_ok);
    check_value("o_mem_req.req", 0, mem_req.req);
  endtask

  task automatic drive_inputs();
    if (issued < tests.size() && gap_left == 0) begin
      valid = 1'b1;
      addr  = tests[issued].addr;
    end else begin
      valid = 1'b0;
      if (gap_left > 0) gap_left--;
    end
  endtask

  task automatic accept_access();
    pending_t p;
    p.idx       = issued;
    p.acc_cyc   = cycle_q;
    p.err_base  = errors;
    p.miss_seen = 1'b0;
    if (issued > 0 && !tests[issued-1].miss && tests[issued].gap == 0) begin
      check_value("accept cycle", prev_acc + 1, cycle_q);   // back-to-back behind a hit
    end
    prev_acc = cycle_q;
    pending.push_back(p);
    issued++;
    gap_left = (issued < tests.size()) ? tests[issued].gap : 0;
  endtask

  task automatic finish_access();
    pending_t  p;
    test_rec_t t;
    if (pending.size() == 0) begin
      report_error("o_data_ok with no access outstanding");
    end else begin
      p = pending.pop_front();
      t = tests[p.idx];
      check_value("o_rdata", t.word, rdata);
      check_value("miss", t.miss, p.miss_seen);
      if (!t.miss) check_value("data_ok latency", 1, cycle_q - p.acc_cyc);
      if (errors != p.err_base) tests_failed++;
      $display("test %0d addr %h %s: %s", p.idx, t.addr, t.miss ? "miss" : "hit",
               (errors == p.err_base) ? "ok" : "fail");
      done_count++;
    end
  endtask

  task automatic sample_outputs();
    pending_t p;
    if (mem_req.req && !req_prev) begin
      if (pending.size() == 0) begin
        report_error("memory request with no access outstanding");
      end else begin
        p = pending.pop_front();
        p.miss_seen = 1'b1;
        check_value("o_mem_req.rd_type", LINE, mem_req.rd_type);
        check_value("o_mem_req.addr", tests[p.idx].addr & ~addr_t'(LINE_WORDS * 8 - 1),
                    mem_req.addr);
        pending.push_front(p);
      end
    end
    req_prev = mem_req.req;
    if (data_ok) finish_access();
    if (valid && addr_ok) accept_access();
  endtask

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    int reset_err_base;
    rst          = 1'b1;
    valid        = 1'b0;
    addr         = '0;
    errors       = 0;
    tests_failed = 0;
    done_count   = 0;
    issued       = 0;
    req_prev     = 1'b0;
    prev_acc     = '0;
    load_tests();
    if (tests.size() == 0) report_error("no accesses in the test file");
    loaded = 1'b1;
    reset_err_base = errors;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      if (i == 2) begin
        #(DRIVE_DLY);
        rst = 1'b0;         // last check lands just after reset
      end
      @(negedge clk);
      check_reset_outputs();
    end
    if (errors != reset_err_base) tests_failed++;
    $display("test reset: %s", (errors == reset_err_base) ? "ok" : "fail");
    gap_left = (tests.size() > 0) ? tests[0].gap : 0;
    while (done_count < tests.size()) begin
      @(posedge clk);
      #(DRIVE_DLY);
      drive_inputs();
      @(negedge clk);
      sample_outputs();
    end
    repeat (2) @(posedge clk);
    $display("%0d tests, %0d failed, %0d errors", tests.size() + 1, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog budget scales with the number of accesses
  initial begin
    wait (loaded);
    #((tests.size() + 1) * CYCLES_PER_TEST * CLK_PERIOD);
    $display("watchdog: run timed out with %0d of %0d accesses done", done_count, tests.size());
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_icache_mem.sv */
// memory responder for the icache testbench that takes line requests and returns four beats
`timescale 1ns/10ps
`default_nettype none

module tb_icache_mem import icache_pkg::*; #(
  parameter int unsigned SEED      = 47119,
  parameter int unsigned MAX_DELAY = 3,   // longest handshake delay and beat gap
  parameter int          DRIVE_DLY = 5
) (
  input  logic        i_clk,
  input  mem_rd_req_t i_mem_req,
  output logic        o_rd_rdy,
  output mem_ret_t    o_mem_ret
);

  // word k of a line holds the word address low and its inverse high
  function automatic word_t beat_data(addr_t line_addr, int unsigned k);
    addr_t word_addr;
    word_addr = line_addr + addr_t'(8 * k);
    return {~word_addr, word_addr};
  endfunction

  // next point where inputs of the DUT may change
  task automatic drive_slot();
    @(posedge i_clk);
    #(DRIVE_DLY);
  endtask

  // ------------------------------------------------------------------
  // request / beat sequencing
  // ------------------------------------------------------------------
  initial begin
    addr_t line_addr;
    o_rd_rdy  = 1'b0;
    o_mem_ret = '0;
    void'($urandom(SEED));        // one seed for the whole run
    forever begin
      do begin
        @(negedge i_clk);         // sample mid-cycle
      end while (!i_mem_req.req);
      line_addr = i_mem_req.addr;
      repeat ($urandom % (MAX_DELAY + 1)) drive_slot();
      drive_slot();
      o_rd_rdy = 1'b1;            // handshake on the next edge
      drive_slot();
      o_rd_rdy = 1'b0;            // first refill cycle
      for (int k = 0; k < LINE_WORDS; k++) begin
        repeat ($urandom % (MAX_DELAY + 1)) drive_slot();
        o_mem_ret.valid = 1'b1;
        o_mem_ret.last  = (k == LINE_WORDS - 1);
        o_mem_ret.data  = beat_data(line_addr, k);
        drive_slot();
        o_mem_ret = '0;
      end
    end
  end

endmodule

`default_nettype wire

/* src/icache_top.sv */
// icache top level that connects controller, tag array, data array and miss unit
`timescale 1ns/10ps
`default_nettype none

module icache_top import icache_pkg::*; #(
  parameter int NUM_SETS = 64
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_valid,
  input  addr_t       i_addr,
  output logic        o_addr_ok,
  output logic        o_data_ok,
  output word_t       o_rdata,
  output mem_rd_req_t o_mem_req,
  input  logic        i_rd_rdy,
  input  mem_ret_t    i_mem_ret
);

  localparam int IDX_W = $clog2(NUM_SETS);

  // ------------------------------------------------------------------
  // internal nets
  // ------------------------------------------------------------------
  addr_t                 req_addr;
  logic [IDX_W-1:0]      set_idx;
  logic                  refill;
  logic                  req_fire;
  logic                  hit;
  logic                  hit_way;
  word_t                 hit_word;
  logic                  crit_beat;
  logic                  fill_we;
  logic                  fill_way;
  logic [IDX_W-1:0]      fill_set;
  logic [WORD_SEL_W-1:0] fill_word_sel;
  word_t                 fill_word;
  logic                  fill_done;

  // ------------------------------------------------------------------
  // blocks
  // ------------------------------------------------------------------
  icache_ctrl #(.NUM_SETS(NUM_SETS)) u_ctrl (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_addr      (i_addr),
    .i_hit       (hit),
    .i_hit_word  (hit_word),
    .i_crit_beat (crit_beat),
    .i_mem_ret   (i_mem_ret),
    .i_rd_rdy    (i_rd_rdy),
    .o_addr_ok   (o_addr_ok),
    .o_data_ok   (o_data_ok),
    .o_rdata     (o_rdata),
    .o_req_addr  (req_addr),
    .o_set_idx   (set_idx),
    .o_refill    (refill),
    .o_req_fire  (req_fire),
    .o_mem_req   (o_mem_req)
  );

  icache_tag_array #(.NUM_SETS(NUM_SETS)) u_tag (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_req_addr  (req_addr),
    .i_fill_done (fill_done),
    .i_fill_way  (fill_way),
    .o_hit       (hit),
    .o_hit_way   (hit_way)
  );

  icache_data_array #(.NUM_SETS(NUM_SETS)) u_data (
    .i_clk           (i_clk),
    .i_set_idx       (set_idx),
    .i_word_sel      (req_addr[OFFSET_W-1 -: WORD_SEL_W]),  // addr[4:3]
    .i_hit_way       (hit_way),
    .i_fill_we       (fill_we),
    .i_fill_way      (fill_way),
    .i_fill_set      (fill_set),
    .i_fill_word_sel (fill_word_sel),
    .i_fill_word     (fill_word),
    .o_word          (hit_word)
  );

  icache_miss_unit #(.NUM_SETS(NUM_SETS)) u_miss (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_req_addr      (req_addr),
    .i_refill        (refill),
    .i_req_fire      (req_fire),
    .i_mem_ret       (i_mem_ret),
    .o_fill_we       (fill_we),
    .o_fill_way      (fill_way),
    .o_fill_set      (fill_set),
    .o_fill_word_sel (fill_word_sel),
    .o_fill_word     (fill_word),
    .o_fill_done     (fill_done),
    .o_crit_beat     (crit_beat)
  );

endmodule

`default_nettype wire

/* src/icache_ctrl.sv */
// icache FSM, request buffer, data-array index select and processor-side outputs
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl import icache_pkg::*; #(
  parameter int NUM_SETS = 64
) (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic                        i_valid,
  input  addr_t                       i_addr,
  input  logic                        i_hit,
  input  word_t                       i_hit_word,
  input  logic                        i_crit_beat,
  input  mem_ret_t                    i_mem_ret,
  input  logic                        i_rd_rdy,
  output logic                        o_addr_ok,
  output logic                        o_data_ok,
  output word_t                       o_rdata,
  output addr_t                       o_req_addr,
  output logic [$clog2(NUM_SETS)-1:0] o_set_idx,
  output logic                        o_refill,
  output logic                        o_req_fire,
  output mem_rd_req_t                 o_mem_req
);

  localparam int IDX_W = $clog2(NUM_SETS);

  cache_state_e state_q;
  cache_state_e state_d;
  addr_t        req_addr_q;
  logic         accept;
  logic         lookup_hit;

  assign lookup_hit = (state_q == LOOKUP) & i_hit;
  assign accept     = i_valid & o_addr_ok;

  // ------------------------------------------------------------------
  // state machine
  // ------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (i_valid) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (!i_hit) begin
          state_d = MISS;
        end else if (!i_valid) begin
          state_d = IDLE;   // hit with nothing behind it
        end
      end
      MISS: begin
        if (i_rd_rdy) begin
          state_d = REFILL;
        end
      end
      REFILL: begin
        if (i_mem_ret.valid && i_mem_ret.last) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // request buffer loads on every accepted request
  always_ff @(posedge i_clk) begin
    if (accept) begin
      req_addr_q <= i_addr;
    end
  end

  // ------------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------------
  assign o_addr_ok  = (state_q == IDLE) | lookup_hit;
  assign o_data_ok  = lookup_hit | ((state_q == REFILL) & i_crit_beat);
  assign o_rdata    = (state_q == LOOKUP) ? i_hit_word : i_mem_ret.data;  // crit beat passes through
  assign o_req_addr = req_addr_q;
  assign o_refill   = (state_q == REFILL);
  assign o_req_fire = (state_q == MISS) & i_rd_rdy;

  // incoming index on accept so the sync read lands in the next LOOKUP
  assign o_set_idx = accept ? i_addr[OFFSET_W +: IDX_W] : req_addr_q[OFFSET_W +: IDX_W];

  always_comb begin
    o_mem_req.req     = (state_q == MISS);
    o_mem_req.rd_type = LINE;
    o_mem_req.addr    = {req_addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};  // line aligned
  end

endmodule

`default_nettype wire

/* src/icache_miss_unit.sv */
// refill beat counter, victim way pointer and fill-write / critical-word generation
`timescale 1ns/10ps
`default_nettype none

module icache_miss_unit import icache_pkg::*; #(
  parameter int NUM_SETS = 64
) (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  addr_t                       i_req_addr,
  input  logic                        i_refill,
  input  logic                        i_req_fire,
  input  mem_ret_t                    i_mem_ret,
  output logic                        o_fill_we,
  output logic                        o_fill_way,
  output logic [$clog2(NUM_SETS)-1:0] o_fill_set,
  output logic [WORD_SEL_W-1:0]       o_fill_word_sel,
  output word_t                       o_fill_word,
  output logic                        o_fill_done,
  output logic                        o_crit_beat
);

  localparam int IDX_W = $clog2(NUM_SETS);

  logic [WORD_SEL_W-1:0] beat_q;     // index of the next beat
  logic                  victim_q;   // way to replace
  logic                  beat_in;

  assign beat_in = i_refill & i_mem_ret.valid;

  // ------------------------------------------------------------------
  // counters
  // ------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst || i_req_fire) begin
      beat_q <= '0;
    end else if (beat_in) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  // flips once per completed line
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      victim_q <= 1'b0;
    end else if (o_fill_done) begin
      victim_q <= ~victim_q;
    end
  end

  // ------------------------------------------------------------------
  // fill writes
  // ------------------------------------------------------------------
  assign o_fill_we       = beat_in;
  assign o_fill_way      = victim_q;
  assign o_fill_set      = i_req_addr[OFFSET_W +: IDX_W];
  assign o_fill_word_sel = beat_q;        // beats arrive in word order
  assign o_fill_word     = i_mem_ret.data;
  assign o_fill_done     = beat_in & i_mem_ret.last;

  // beat carrying the word the processor asked for
  assign o_crit_beat = beat_in & (beat_q == i_req_addr[OFFSET_W-1 -: WORD_SEL_W]);

endmodule

`default_nettype wire

/* src/icache_data_array.sv */
// two-way line store with one-cycle read, word select and per-beat fill writes
`timescale 1ns/10ps
`default_nettype none

module icache_data_array import icache_pkg::*; #(
  parameter int NUM_SETS = 64
) (
  input  logic                        i_clk,
  input  logic [$clog2(NUM_SETS)-1:0] i_set_idx,
  input  logic [WORD_SEL_W-1:0]       i_word_sel,
  input  logic                        i_hit_way,
  input  logic                        i_fill_we,
  input  logic                        i_fill_way,
  input  logic [$clog2(NUM_SETS)-1:0] i_fill_set,
  input  logic [WORD_SEL_W-1:0]       i_fill_word_sel,
  input  word_t                       i_fill_word,
  output word_t                       o_word
);

  localparam int NUM_WAYS = 2;

  word_t mem_q [NUM_WAYS][NUM_SETS][LINE_WORDS];
  word_t rd_q  [NUM_WAYS][LINE_WORDS];   // both ways of the read set

  // ------------------------------------------------------------------
  // fill port writes one word per returned beat
  // ------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_fill_we) begin
      mem_q[i_fill_way][i_fill_set][i_fill_word_sel] <= i_fill_word;
    end
  end

  // ------------------------------------------------------------------
  // read port
  // ------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int k = 0; k < LINE_WORDS; k++) begin
        rd_q[w][k] <= mem_q[w][i_set_idx][k];
      end
    end
  end

  // way from the tag compare, word from the held address
  assign o_word = rd_q[i_hit_way][i_word_sel];

endmodule

`default_nettype wire

/* src/icache_tag_array.sv */
// two-way tag/valid store with combinational hit compare and refill update
`timescale 1ns/10ps
`default_nettype none

module icache_tag_array import icache_pkg::*; #(
  parameter int NUM_SETS = 64
) (
  input  logic  i_clk,
  input  logic  i_rst,
  input  addr_t i_req_addr,
  input  logic  i_fill_done,
  input  logic  i_fill_way,
  output logic  o_hit,
  output logic  o_hit_way
);

  localparam int NUM_WAYS = 2;
  localparam int IDX_W    = $clog2(NUM_SETS);
  localparam int TAG_W    = ADDR_W - OFFSET_W - IDX_W;  // everything above the index

  logic [TAG_W-1:0]    tag_q   [NUM_WAYS][NUM_SETS];
  logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
  logic [IDX_W-1:0]    req_idx;
  logic [TAG_W-1:0]    req_tag;
  logic [NUM_WAYS-1:0] way_hit;

  assign req_idx = i_req_addr[OFFSET_W +: IDX_W];
  assign req_tag = i_req_addr[ADDR_W-1 -: TAG_W];

  // ------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        valid_q[w] <= '0;   // cold cache
      end
    end else if (i_fill_done) begin
      valid_q[i_fill_way][req_idx] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fill_done) begin
      tag_q[i_fill_way][req_idx] <= req_tag;  // written with the last beat
    end
  end

  // ------------------------------------------------------------------
  // compare against the held request
  // ------------------------------------------------------------------
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit[w] = valid_q[w][req_idx] && (tag_q[w][req_idx] == req_tag);
    end
  end

  assign o_hit     = |way_hit;
  assign o_hit_way = way_hit[1];  // ways never both match

endmodule

`default_nettype wire

/* src/icache_pkg.sv */
// shared widths, address split, FSM/burst enums and memory-port bundles for the icache
`default_nettype none

package icache_pkg;

  // ------------------------------------------------------------------
  // widths and address split
  // ------------------------------------------------------------------
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 64;
  localparam int LINE_WORDS = 4;   // 32-byte line
  localparam int OFFSET_W   = 5;   // byte offset inside a line
  localparam int WORD_SEL_W = 2;   // addr[4:3]

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;

  // ------------------------------------------------------------------
  // enums
  // ------------------------------------------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    LOOKUP = 2'd1,
    MISS   = 2'd2,   // line request outstanding
    REFILL = 2'd3    // beats coming back
  } cache_state_e;

  typedef enum logic [2:0] {
    BYTE = 3'b001,
    HALF = 3'b010,
    WORD = 3'b100,
    LINE = 3'b111    // the only burst an icache issues
  } rd_type_e;

  // ------------------------------------------------------------------
  // memory-side bundles
  // ------------------------------------------------------------------
  typedef struct packed {
    logic     req;       // held until rd_rdy
    rd_type_e rd_type;
    addr_t    addr;      // line aligned
  } mem_rd_req_t;        // 36 bits

  typedef struct packed {
    logic  valid;
    logic  last;         // set on beat 3
    word_t data;
  } mem_ret_t;           // 66 bits

endpackage

`default_nettype wire
